/* list.f */
logic/tile_pkg.sv
logic/tile_config_decode.sv
logic/connect_box.sv
logic/logic_block.sv
logic/switch_box.sv
logic/pe_tile.sv
verif/pe_tile_chk.sv
verif/pe_tile_tb.sv

/* logic/connect_box.sv */
`default_nettype none

module connect_box (
	input wire clk,
	input wire arst_n,
	input wire config_en,
	input wire [tile_pkg::cb_sel_w-1:0] config_data,
	input wire tile_pkg::track_t near_tracks,
	input wire tile_pkg::track_t far_tracks,
	output logic block_out
);

	logic [tile_pkg::cb_sel_w-1:0] sel_q;
	logic [2*tile_pkg::num_tracks-1:0] tracks;

	// The select loads on every edge while the address points here.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_q <= '0;
		end else if (config_en) begin
			sel_q <= config_data;
		end
	end

	// Selects 0 to 3 reach the side's inputs and 4 to 7 the side's outputs.
	assign tracks = {far_tracks, near_tracks};

	assign block_out = tracks[sel_q];

endmodule

`default_nettype wire

/* logic/logic_block.sv */
`default_nettype none

module logic_block (
	input wire clk,
	input wire arst_n,
	input wire config_en,
	input wire tile_pkg::clb_op_t config_data,
	input wire in0,
	input wire in1,
	output logic pe_out
);

	tile_pkg::clb_op_t op_q;
	logic result;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_q <= tile_pkg::op_and;
		end else if (config_en) begin
			op_q <= config_data;
		end
	end

	always_comb begin
		case (op_q)
			tile_pkg::op_and: begin
				result = in0 & in1;
			end
			tile_pkg::op_or: begin
				result = in0 | in1;
			end
			tile_pkg::op_xor: begin
				result = in0 ^ in1;
			end
			tile_pkg::op_nand: begin
				result = ~(in0 & in1);
			end
			tile_pkg::op_nor: begin
				result = ~(in0 | in1);
			end
			tile_pkg::op_xnor: begin
				result = ~(in0 ^ in1);
			end
			tile_pkg::op_in0: begin
				result = in0;
			end
			tile_pkg::op_in1: begin
				result = in1;
			end
			default: begin
				result = 1'b0;
			end
		endcase
	end

	// The result is registered on every edge. Feedback from the output tracks
	// into the connect boxes therefore always passes through this flop.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pe_out <= 1'b0;
		end else begin
			pe_out <= result;
		end
	end

endmodule

`default_nettype wire

/* logic/pe_tile.sv */
`default_nettype none

module pe_tile (
	input wire clk,
	input wire arst_n,
	input wire tile_pkg::cfg_addr_t config_addr,
	input wire [tile_pkg::cfg_data_w-1:0] config_data,
	input wire [tile_pkg::tile_id_w-1:0] tile_id,
	input wire tile_pkg::side_bus_t in_tracks,
	output tile_pkg::side_bus_t out_tracks
);

	tile_pkg::cfg_en_t cfg_en;
	logic op0;
	logic op1;
	logic pe_out;

	tile_config_decode decode_i (
		.config_addr(config_addr),
		.tile_id(tile_id),
		.cfg_en(cfg_en)
	);

	// Each connect box sees one side: its inputs first, then its outputs.
	connect_box cb0_i (
		.clk(clk),
		.arst_n(arst_n),
		.config_en(cfg_en.cb0),
		.config_data(config_data[tile_pkg::cb_sel_w-1:0]),
		.near_tracks(in_tracks.side0),
		.far_tracks(out_tracks.side0),
		.block_out(op0)
	);

	connect_box cb1_i (
		.clk(clk),
		.arst_n(arst_n),
		.config_en(cfg_en.cb1),
		.config_data(config_data[tile_pkg::cb_sel_w-1:0]),
		.near_tracks(in_tracks.side1),
		.far_tracks(out_tracks.side1),
		.block_out(op1)
	);

	logic_block clb_i (
		.clk(clk),
		.arst_n(arst_n),
		.config_en(cfg_en.clb),
		.config_data(tile_pkg::clb_op_t'(config_data[tile_pkg::clb_op_w-1:0])),
		.in0(op0),
		.in1(op1),
		.pe_out(pe_out)
	);

	switch_box sb_i (
		.clk(clk),
		.arst_n(arst_n),
		.config_en(cfg_en.sb),
		.config_data(tile_pkg::sb_cfg_t'(config_data)),
		.in_tracks(in_tracks),
		.pe_out(pe_out),
		.out_tracks(out_tracks)
	);

endmodule

`default_nettype wire

/* logic/switch_box.sv */
`default_nettype none

module switch_box (
	input wire clk,
	input wire arst_n,
	input wire config_en,
	input wire tile_pkg::sb_cfg_t config_data,
	input wire tile_pkg::side_bus_t in_tracks,
	input wire pe_out,
	output tile_pkg::side_bus_t out_tracks
);

	tile_pkg::sb_cfg_t cfg_q;
	logic [tile_pkg::num_sides-1:0][tile_pkg::num_tracks-1:0] in_arr;
	wire [tile_pkg::num_sides-1:0][tile_pkg::num_tracks-1:0] out_arr;

	// An all-zero register selects sel_pe everywhere.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q <= '0;
		end else if (config_en) begin
			cfg_q <= config_data;
		end
	end

	assign in_arr = in_tracks;

	for (genvar s = 0; s < tile_pkg::num_sides; s++) begin : g_side
		localparam int side_a = tile_pkg::other_side(s, 0);
		localparam int side_b = tile_pkg::other_side(s, 1);
		localparam int side_c = tile_pkg::other_side(s, 2);

		for (genvar t = 0; t < tile_pkg::num_tracks; t++) begin : g_track
			tile_pkg::sb_sel_t sel;
			logic routed;

			assign sel = cfg_q.sel[s*tile_pkg::num_tracks+t];

			// A track only ever continues on the same track number.
			always_comb begin
				case (sel)
					tile_pkg::sel_pe: begin
						routed = pe_out;
					end
					tile_pkg::sel_a: begin
						routed = in_arr[side_a][t];
					end
					tile_pkg::sel_b: begin
						routed = in_arr[side_b][t];
					end
					tile_pkg::sel_c: begin
						routed = in_arr[side_c][t];
					end
					default: begin
						routed = pe_out;
					end
				endcase
			end

			assign out_arr[s][t] = routed;
		end
	end

	assign out_tracks = out_arr;

endmodule

`default_nettype wire

/* logic/tile_config_decode.sv */
`default_nettype none

module tile_config_decode (
	input wire tile_pkg::cfg_addr_t config_addr,
	input wire [tile_pkg::tile_id_w-1:0] tile_id,
	output tile_pkg::cfg_en_t cfg_en
);

	logic tile_hit;
	logic sb_hit;
	logic cb0_hit;
	logic cb1_hit;
	logic clb_hit;

	assign tile_hit = (config_addr.tile == tile_id);

	// The identifiers differ, so at most one block can match.
	assign sb_hit = (config_addr.block == tile_pkg::blk_sb);
	assign cb0_hit = (config_addr.block == tile_pkg::blk_cb0);
	assign cb1_hit = (config_addr.block == tile_pkg::blk_cb1);
	assign clb_hit = (config_addr.block == tile_pkg::blk_clb);

	always_comb begin
		cfg_en = '0;
		if (tile_hit) begin
			cfg_en.sb = sb_hit;
			cfg_en.cb0 = cb0_hit;
			cfg_en.cb1 = cb1_hit;
			cfg_en.clb = clb_hit;
		end
	end

endmodule

`default_nettype wire

/* logic/tile_pkg.sv */
`default_nettype none

package tile_pkg;

	localparam int num_sides = 4;
	localparam int num_tracks = 4;
	localparam int tile_id_w = 16;
	localparam int cfg_data_w = 32;
	localparam int cb_sel_w = 3;
	localparam int clb_op_w = 3;

	// Block identifiers in the high half of the configuration address.
	// Zero is never a block, so an all-zero address leaves the tile idle.
	localparam logic [tile_id_w-1:0] blk_sb = 16'd7;
	localparam logic [tile_id_w-1:0] blk_cb0 = 16'd6;
	localparam logic [tile_id_w-1:0] blk_cb1 = 16'd5;
	localparam logic [tile_id_w-1:0] blk_clb = 16'd4;

	// Track t0 sits in bit 0.
	typedef struct packed {
		logic t3;
		logic t2;
		logic t1;
		logic t0;
	} track_t;

	// Side 0 sits in the low nibble, so the bus also reads as [side][track].
	typedef struct packed {
		track_t side3;
		track_t side2;
		track_t side1;
		track_t side0;
	} side_bus_t;

	typedef struct packed {
		logic [tile_id_w-1:0] block;
		logic [tile_id_w-1:0] tile;
	} cfg_addr_t;

	typedef struct packed {
		logic sb;
		logic cb0;
		logic cb1;
		logic clb;
	} cfg_en_t;

	typedef enum logic [clb_op_w-1:0] {
		op_and,
		op_or,
		op_xor,
		op_nand,
		op_nor,
		op_xnor,
		op_in0,
		op_in1
	} clb_op_t;

	// The three side selects count the other sides upward and skip the output's own side.
	typedef enum logic [1:0] {
		sel_pe = 2'd0,
		sel_a = 2'd1,
		sel_b = 2'd2,
		sel_c = 2'd3
	} sb_sel_t;

	// Entry 4s+t routes output side s, track t.
	typedef struct packed {
		sb_sel_t [num_sides*num_tracks-1:0] sel;
	} sb_cfg_t;

	// Returns the side that has the given rank among the sides other than side.
	function automatic int other_side(input int side, input int rank);
		int result;
		if (rank < side) begin
			result = rank;
		end else begin
			result = rank + 1;
		end
		return result;
	endfunction

endpackage

`default_nettype wire

/* verif/pe_tile_chk.sv */
`default_nettype none

module pe_tile_chk (
	input wire clk,
	input wire arst_n,
	input wire tile_pkg::cfg_en_t cfg_en,
	input wire tile_pkg::side_bus_t out_tracks,
	input wire op0,
	input wire op1,
	input wire pe_out
);

	// The block identifiers differ, so one address enables one block at most.
	cfg_en_onehot: assert property (@(posedge clk)
		$onehot0({cfg_en.sb, cfg_en.cb0, cfg_en.cb1, cfg_en.clb}))
		else $error("more than one configuration enable is high at once");

	// The reset clears every flop asynchronously, so by mid-cycle all routing
	// points at a cleared pe_out.
	reset_quiet: assert property (@(negedge clk)
		!arst_n |-> (out_tracks == '0))
		else $error("output tracks are not zero while the tile is in reset");

	// The operation register only changes on an edge where its enable was high.
	pe_hold: assert property (@(posedge clk) disable iff (!arst_n)
		($past(arst_n) && $stable(op0) && $stable(op1) && !$past(cfg_en.clb))
		|=> $stable(pe_out))
		else $error("logic block output changed with stable operands and operation");

endmodule

bind pe_tile pe_tile_chk pe_tile_chk_i (
	.clk(clk),
	.arst_n(arst_n),
	.cfg_en(cfg_en),
	.out_tracks(out_tracks),
	.op0(op0),
	.op1(op1),
	.pe_out(pe_out)
);

`default_nettype wire

/* verif/pe_tile_tb.sv */
`default_nettype none

module pe_tile_tb;

	logic clk;
	logic arst_n;
	tile_pkg::cfg_addr_t config_addr;
	logic [tile_pkg::cfg_data_w-1:0] config_data;
	logic [tile_pkg::tile_id_w-1:0] tile_id;
	tile_pkg::side_bus_t in_tracks;
	tile_pkg::side_bus_t out_tracks;

	// Shadow copy of the tile state.
	tile_pkg::sb_cfg_t sh_sb;
	logic [tile_pkg::cb_sel_w-1:0] sh_cb0;
	logic [tile_pkg::cb_sel_w-1:0] sh_cb1;
	tile_pkg::clb_op_t sh_op;
	logic sh_pe;
	tile_pkg::side_bus_t model_bus;
	logic model_op0;
	logic model_op1;

	logic [31:0] rng_state;
	string test_name;
	int test_errors;
	int pass_count;
	int fail_count;

	pe_tile pe_tile_i (
		.clk(clk),
		.arst_n(arst_n),
		.config_addr(config_addr),
		.config_data(config_data),
		.tile_id(tile_id),
		.in_tracks(in_tracks),
		.out_tracks(out_tracks)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic apply_op(input tile_pkg::clb_op_t op, input logic a, input logic b);
		logic r;
		case (op)
			tile_pkg::op_and: r = a & b;
			tile_pkg::op_or: r = a | b;
			tile_pkg::op_xor: r = a ^ b;
			tile_pkg::op_nand: r = !(a && b);
			tile_pkg::op_nor: r = !(a || b);
			tile_pkg::op_xnor: r = (a == b);
			tile_pkg::op_in0: r = a;
			default: r = b;
		endcase
		return r;
	endfunction

	// Selects 0 to 3 are the side's inputs, 4 to 7 the side's outputs.
	function automatic logic pick_operand(input logic [2:0] sel, input tile_pkg::track_t near,
		input tile_pkg::track_t far);
		logic [3:0] side_bits;
		if (sel < 3'd4) begin
			side_bits = near;
		end else begin
			side_bits = far;
		end
		return side_bits[sel[1:0]];
	endfunction

	function automatic tile_pkg::side_bus_t expected_out(input tile_pkg::sb_cfg_t cfg,
		input tile_pkg::side_bus_t in_bus, input logic pe);
		logic [15:0] in_bits;
		logic [15:0] out_bits;
		int rank;
		int count;
		int src;
		in_bits = in_bus;
		out_bits = '0;
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				rank = int'(cfg.sel[4*s+t]);
				if (rank == 0) begin
					out_bits[4*s+t] = pe;
				end else begin
					count = 0;
					src = 0;
					for (int o = 0; o < 4; o++) begin
						if (o != s) begin
							count++;
							if (count == rank) begin
								src = o;
							end
						end
					end
					out_bits[4*s+t] = in_bits[4*src+t];
				end
			end
		end
		return out_bits;
	endfunction

	function automatic tile_pkg::sb_cfg_t random_side_routes();
		tile_pkg::sb_cfg_t cfg;
		for (int i = 0; i < 16; i++) begin
			cfg.sel[i] = tile_pkg::sb_sel_t'(2'(1 + next_random() % 3));
		end
		return cfg;
	endfunction

	task automatic check_sides(input string name, input tile_pkg::side_bus_t expected,
		input tile_pkg::side_bus_t actual);
		if (actual !== expected) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		// The compare process has checked the last falling edge by the next rising edge.
		@(posedge clk);
		if (test_errors == 0) begin
			pass_count++;
			$display("test %s passed", test_name);
		end else begin
			fail_count++;
			$display("test %s failed with %0d mismatches", test_name, test_errors);
		end
	endtask

	task automatic write_config(input logic [15:0] tile, input logic [15:0] block,
		input logic [31:0] data);
		tile_pkg::cfg_addr_t addr;
		addr.block = block;
		addr.tile = tile;
		@(posedge clk);
		config_addr <= addr;
		config_data <= data;
		@(posedge clk);
		config_addr <= {16'h0000, tile_id};
	endtask

	task automatic random_inputs(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			in_tracks <= 16'(next_random());
		end
	endtask

	task automatic wait_feedback_high();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (out_tracks.side0.t0 !== 1'b1 && cycles < 8) begin
			cycles++;
			@(negedge clk);
		end
		if (out_tracks.side0.t0 !== 1'b1) begin
			$display("timeout: output side 0 track 0 never went high in test %s", test_name);
			test_errors++;
		end
	endtask

	// Inputs only move on rising edges, so the falling edge sees what the
	// next rising edge captures.
	initial begin
		sh_sb = '0;
		sh_cb0 = '0;
		sh_cb1 = '0;
		sh_op = tile_pkg::op_and;
		sh_pe = 1'b0;
		forever begin
			@(negedge clk);
			model_bus = expected_out(sh_sb, in_tracks, sh_pe);
			check_sides(test_name, model_bus, out_tracks);
			if (arst_n) begin
				model_op0 = pick_operand(sh_cb0, in_tracks.side0, model_bus.side0);
				model_op1 = pick_operand(sh_cb1, in_tracks.side1, model_bus.side1);
				sh_pe = apply_op(sh_op, model_op0, model_op1);
				if (config_addr.tile == tile_id) begin
					if (config_addr.block == tile_pkg::blk_sb) begin
						sh_sb = tile_pkg::sb_cfg_t'(config_data);
					end
					if (config_addr.block == tile_pkg::blk_cb0) begin
						sh_cb0 = config_data[2:0];
					end
					if (config_addr.block == tile_pkg::blk_cb1) begin
						sh_cb1 = config_data[2:0];
					end
					if (config_addr.block == tile_pkg::blk_clb) begin
						sh_op = tile_pkg::clb_op_t'(config_data[2:0]);
					end
				end
			end
		end
	end

	initial begin
		#20000;
		$display("timeout: the simulation did not reach its end in time");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		logic [1:0] sel0;
		logic [1:0] sel1;
		logic [15:0] vec;
		logic bit_exp;
		tile_pkg::sb_cfg_t routes;
		rng_state = 32'hdacbdb66;
		pass_count = 0;
		fail_count = 0;
		tile_id = 16'h0012;
		config_addr = {16'h0000, 16'h0012};
		config_data = '0;
		in_tracks = '0;
		arst_n = 1'b0;

		begin_test("reset");
		repeat (7) begin
			@(posedge clk);
			in_tracks <= 16'(next_random());
			@(negedge clk);
			check_sides(test_name, '0, out_tracks);
		end
		@(posedge clk);
		arst_n <= 1'b1;
		in_tracks <= 16'(next_random());
		@(negedge clk);
		check_sides(test_name, '0, out_tracks);
		finish_test();

		begin_test("routing");
		for (int n = 0; n < 10; n++) begin
			write_config(tile_id, tile_pkg::blk_sb, random_side_routes());
			random_inputs(8);
		end
		finish_test();

		// All outputs carry pe_out, so every track shows the operation result.
		begin_test("operations");
		write_config(tile_id, tile_pkg::blk_sb, '0);
		for (int op = 0; op < 8; op++) begin
			sel0 = 2'(next_random());
			sel1 = 2'(next_random());
			write_config(tile_id, tile_pkg::blk_cb0, 32'(sel0));
			write_config(tile_id, tile_pkg::blk_cb1, 32'(sel1));
			write_config(tile_id, tile_pkg::blk_clb, 32'(op));
			repeat (4) begin
				vec = 16'(next_random());
				@(posedge clk);
				in_tracks <= vec;
				@(posedge clk);
				@(negedge clk);
				bit_exp = apply_op(tile_pkg::clb_op_t'(op), vec[sel0], vec[4 + sel1]);
				check_sides(test_name, {16{bit_exp}}, out_tracks);
			end
		end
		finish_test();

		// Side 1 alternates and side 0 is low, so any stray routing, select or
		// operation write would move the outputs.
		begin_test("address filter");
		vec = 16'h0050;
		@(posedge clk);
		in_tracks <= vec;
		write_config(tile_id ^ 16'h0001, tile_pkg::blk_sb, 32'h5555_5555);
		write_config(tile_id ^ 16'h0100, tile_pkg::blk_clb, 32'(tile_pkg::op_nor));
		write_config(tile_id ^ 16'h0020, tile_pkg::blk_cb1, 32'(sel1 ^ 2'd1));
		write_config(tile_id, 16'd0, next_random());
		write_config(tile_id, 16'd3, next_random());
		repeat (2) begin
			@(posedge clk);
		end
		@(negedge clk);
		bit_exp = apply_op(tile_pkg::op_in1, vec[sel0], vec[4 + sel1]);
		check_sides(test_name, {16{bit_exp}}, out_tracks);
		finish_test();

		// Track 4 of side 0 is pe_out itself, and xor with a constant one inverts it.
		begin_test("feedback");
		routes = random_side_routes();
		routes.sel[0] = tile_pkg::sel_pe;
		@(posedge clk);
		in_tracks <= 16'(next_random()) | 16'h0010;
		write_config(tile_id, tile_pkg::blk_sb, routes);
		write_config(tile_id, tile_pkg::blk_cb1, 32'd0);
		write_config(tile_id, tile_pkg::blk_clb, 32'(tile_pkg::op_xor));
		write_config(tile_id, tile_pkg::blk_cb0, 32'd4);
		wait_feedback_high();
		bit_exp = 1'b1;
		repeat (12) begin
			@(negedge clk);
			bit_exp = ~bit_exp;
			check_sides(test_name, expected_out(routes, in_tracks, bit_exp), out_tracks);
		end
		finish_test();

		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
